//--- test/lsu_stimulus.txt
# all hex: op imm operand_a operand_b trans_id result exc cause name
# op: 0 LB 1 LBU 2 LH 3 LHU 4 LW 5 LWU 6 LD 7 SB 8 SH 9 SW a SD
a 10 f0 8070f1e27f0a9c31 0 0 0 0 sd_pattern
6 0 100 0 1 8070f1e27f0a9c31 0 0 ld_pattern
0 0 100 0 2 31 0 0 lb_off0
0 1 100 0 3 ffffffffffffff9c 0 0 lb_off1
0 2 100 0 4 a 0 0 lb_off2
0 3 100 0 5 7f 0 0 lb_off3
0 4 100 0 6 ffffffffffffffe2 0 0 lb_off4
0 5 100 0 7 fffffffffffffff1 0 0 lb_off5
0 6 100 0 0 70 0 0 lb_off6
0 ffffffffffffffff 108 0 1 ffffffffffffff80 0 0 lb_off7
1 1 100 0 2 9c 0 0 lbu_off1
1 7 100 0 3 80 0 0 lbu_off7
2 0 100 0 4 ffffffffffff9c31 0 0 lh_off0
2 2 100 0 5 7f0a 0 0 lh_off2
2 4 100 0 6 fffffffffffff1e2 0 0 lh_off4
2 6 100 0 7 ffffffffffff8070 0 0 lh_off6
3 6 100 0 0 8070 0 0 lhu_off6
4 0 100 0 1 7f0a9c31 0 0 lw_off0
4 4 100 0 2 ffffffff8070f1e2 0 0 lw_off4
5 4 100 0 3 8070f1e2 0 0 lwu_off4
a 8 100 0123456789abcdef 4 0 0 0 sd_base
7 9 100 123456789abcde5a 5 0 0 0 sb_lane1
8 c 100 ffffffffffffbeef 6 0 0 0 sh_lane45
6 8 100 0 7 0123beef89ab5aef 0 0 ld_after_sb_sh
9 8 100 aaaaaaaacafef00d 0 0 0 0 sw_lane03
6 8 100 0 1 0123beefcafef00d 0 0 ld_after_sw
6 3 100 0 2 0 1 4 ld_misaligned
2 1 100 0 3 0 1 4 lh_misaligned
9 a 100 11223344 4 0 1 6 sw_misaligned
a 4 100 deadbeefdeadbeef 5 0 1 6 sd_misaligned
6 0 100 0 6 8070f1e27f0a9c31 0 0 ld_unchanged0
6 8 100 0 7 0123beefcafef00d 0 0 ld_unchanged1
6 100 0000008000000000 0 0 0 1 d ld_noncanon
a 3 8000000000000100 5a5a 1 0 1 f sd_noncanon_mis
4 2 ffffff0000000000 0 2 0 1 d lw_noncanon_mis
a 100 fffffffffffff000 5555aaaa3333cccc 3 0 0 0 sd_high
6 ffffffffffffff00 fffffffffffff200 0 4 5555aaaa3333cccc 0 0 ld_high

//--- tb.f
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_req_buffer.sv
rtl/lsu_addr_check.sv
rtl/lsu_apb_master.sv
rtl/lsu_top.sv
test/tb_lsu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_lsu -f tb.f

out=$(./obj_dir/Vtb_lsu || true)
printf '%s\n' "$out"

# exit status of the script follows the search
printf '%s\n' "$out" | grep -qx 'Test passed'

//--- test/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  lsu_valid_i;
    lsu_op_e               operator_i;
    logic [XLEN-1:0]       operand_a_i;
    logic [XLEN-1:0]       operand_b_i;
    logic [XLEN-1:0]       imm_i;
    logic [TRANS_ID_W-1:0] trans_id_i;
    logic                  lsu_ready_o;
    logic                  lsu_valid_o;
    logic [TRANS_ID_W-1:0] lsu_trans_id_o;
    logic [XLEN-1:0]       lsu_result_o;
    logic                  ex_valid_o;
    exc_cause_e            ex_cause_o;
    logic [XLEN-1:0]       ex_tval_o;
    logic                  psel_o;
    logic                  penable_o;
    logic                  pwrite_o;
    logic [APB_ADDR_W-1:0] paddr_o;
    logic [XLEN-1:0]       pwdata_o;
    logic [BE_W-1:0]       pstrb_o;
    logic                  pready_i;
    logic [XLEN-1:0]       prdata_i;

    // stimulus lines as read from the file
    logic [3:0]            st_op[$];
    logic [XLEN-1:0]       st_imm[$];
    logic [XLEN-1:0]       st_a[$];
    logic [XLEN-1:0]       st_b[$];
    logic [TRANS_ID_W-1:0] st_tid[$];
    logic [XLEN-1:0]       st_res[$];
    logic                  st_ex[$];
    logic [3:0]            st_cause[$];
    string                 st_name[$];

    // results still owed by the DUT, oldest first
    string                 exp_name[$];
    logic [TRANS_ID_W-1:0] exp_tid[$];
    logic [XLEN-1:0]       exp_res[$];
    logic                  exp_ex[$];
    logic [3:0]            exp_cause[$];
    logic [XLEN-1:0]       exp_tval[$];

    logic [XLEN-1:0]       mem[8192];
    logic [31:0]           lfsr_state = 32'h5a955a26;
    int                    wait_left = 0;
    int                    error_cnt = 0;
    int                    check_cnt = 0;
    int                    cycle_cnt = 0;
    int                    cycle_limit = 1000;

    lsu_top dut0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lsu_valid_i    (lsu_valid_i),
        .operator_i     (operator_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .imm_i          (imm_i),
        .trans_id_i     (trans_id_i),
        .lsu_ready_o    (lsu_ready_o),
        .lsu_valid_o    (lsu_valid_o),
        .lsu_trans_id_o (lsu_trans_id_o),
        .lsu_result_o   (lsu_result_o),
        .ex_valid_o     (ex_valid_o),
        .ex_cause_o     (ex_cause_o),
        .ex_tval_o      (ex_tval_o),
        .psel_o         (psel_o),
        .penable_o      (penable_o),
        .pwrite_o       (pwrite_o),
        .paddr_o        (paddr_o),
        .pwdata_o       (pwdata_o),
        .pstrb_o        (pstrb_o),
        .pready_i       (pready_i),
        .prdata_i       (prdata_i)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = value * 2 + int'(lfsr_state[0]);
        end
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        check_cnt++;
        assert (actual === expected) else begin
            error_cnt++;
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic load_stimulus();
        int                    fd;
        int                    fields;
        string                 line;
        string                 name;
        logic [3:0]            op;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [TRANS_ID_W-1:0] tid;
        logic [XLEN-1:0]       res;
        logic                  ex;
        logic [3:0]            cause;
        fd = $fopen("test/lsu_stimulus.txt", "r");
        assert (fd != 0) else begin
            error_cnt++;
            $display("could not open test/lsu_stimulus.txt");
        end
        if (fd != 0) begin
            // comment and blank lines do not match all nine fields
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %s",
                                 op, imm, a, b, tid, res, ex, cause, name);
                if (fields == 9) begin
                    st_op.push_back(op);
                    st_imm.push_back(imm);
                    st_a.push_back(a);
                    st_b.push_back(b);
                    st_tid.push_back(tid);
                    st_res.push_back(res);
                    st_ex.push_back(ex);
                    st_cause.push_back(cause);
                    st_name.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_request(input int idx);
        logic accepted;
        lsu_valid_i = 1'b1;
        operator_i  = lsu_op_e'(st_op[idx]);
        imm_i       = st_imm[idx];
        operand_a_i = st_a[idx];
        operand_b_i = st_b[idx];
        trans_id_i  = st_tid[idx];
        accepted    = 1'b0;
        while (!accepted) begin
            // ready is registered so its mid-cycle value holds at the edge
            @(negedge clk_i);
            accepted = lsu_ready_o;
            @(posedge clk_i);
            #1;
        end
        exp_name.push_back(st_name[idx]);
        exp_tid.push_back(st_tid[idx]);
        exp_res.push_back(st_res[idx]);
        exp_ex.push_back(st_ex[idx]);
        exp_cause.push_back(st_cause[idx]);
        // faulting address is base plus immediate
        exp_tval.push_back(st_a[idx] + st_imm[idx]);
    endtask

    task automatic compare_result();
        string                 name;
        logic [TRANS_ID_W-1:0] tid;
        logic [XLEN-1:0]       res;
        logic                  ex;
        logic [3:0]            cause;
        logic [XLEN-1:0]       tval;
        name  = exp_name.pop_front();
        tid   = exp_tid.pop_front();
        res   = exp_res.pop_front();
        ex    = exp_ex.pop_front();
        cause = exp_cause.pop_front();
        tval  = exp_tval.pop_front();
        check_value(name, "trans_id", 64'(tid), 64'(lsu_trans_id_o));
        check_value(name, "result", res, lsu_result_o);
        check_value(name, "ex_valid", 64'(ex), 64'(ex_valid_o));
        check_value(name, "cause", 64'(cause), 64'(ex_cause_o));
        if (ex) begin
            check_value(name, "tval", tval, ex_tval_o);
        end
    endtask

    // ------------------------------
    // APB memory model
    // ------------------------------
    assign prdata_i = mem[paddr_o[15:3]];

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(negedge clk_i);
            // reads carry no strobes
            if (psel_o && !pwrite_o) begin
                check_value("apb_read", "pstrb", '0, 64'(pstrb_o));
            end
            if (psel_o && penable_o && pready_i && pwrite_o) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (pstrb_o[b]) begin
                        mem[paddr_o[15:3]][8*b +: 8] = pwdata_o[8*b +: 8];
                    end
                end
            end
        end
    end

    // 0 to 3 wait states picked in the setup phase
    initial begin
        pready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (psel_o && !penable_o) begin
                draw_bits(2, wait_left);
                pready_i = 1'b0;
            end else if (psel_o && penable_o && wait_left == 0) begin
                pready_i = 1'b1;
            end else if (psel_o && penable_o) begin
                pready_i = 1'b0;
                wait_left--;
            end else begin
                pready_i = 1'b0;
            end
        end
    end

    // ------------------------------
    // result monitor
    // ------------------------------
    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                assert (lsu_valid_o || !ex_valid_o) else begin
                    error_cnt++;
                    $display("ex_valid_o was raised without lsu_valid_o");
                end
                if (lsu_valid_o) begin
                    assert (exp_tid.size() != 0) else begin
                        error_cnt++;
                        $display("a result arrived with no request outstanding");
                    end
                    if (exp_tid.size() != 0) begin
                        compare_result();
                    end
                end
            end
        end
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timed out after %0d cycles with %0d results missing",
                 cycle_cnt, exp_tid.size());
        $display("checks: %0d  errors: %0d", check_cnt, error_cnt + 1);
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_ni      = 1'b0;
        lsu_valid_i = 1'b0;
        operator_i  = LB;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        trans_id_i  = '0;
        load_stimulus();
        cycle_limit = 20 * st_op.size() + 50;
        assert (st_op.size() != 0) else begin
            error_cnt++;
            $display("no stimulus lines were read");
        end
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        assert (lsu_ready_o && !psel_o && !penable_o && !lsu_valid_o && !ex_valid_o)
        else begin
            error_cnt++;
            $display("outputs are not in their idle state after reset");
        end
        @(posedge clk_i);
        #1;
        for (int i = 0; i < st_op.size(); i++) begin
            issue_request(i);
        end
        lsu_valid_i = 1'b0;
        while (exp_tid.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (4) @(posedge clk_i);
        $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            lsu_valid_i,
    input  lsu_pkg::lsu_op_e                operator_i,
    input  logic [lsu_pkg::XLEN-1:0]        operand_a_i,
    input  logic [lsu_pkg::XLEN-1:0]        operand_b_i,
    input  logic [lsu_pkg::XLEN-1:0]        imm_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]  trans_id_i,
    output logic                            lsu_ready_o,
    output logic                            lsu_valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]  lsu_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]        lsu_result_o,
    output logic                            ex_valid_o,
    output lsu_pkg::exc_cause_e             ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]        ex_tval_o,
    output logic                            psel_o,
    output logic                            penable_o,
    output logic                            pwrite_o,
    output logic [lsu_pkg::APB_ADDR_W-1:0]  paddr_o,
    output logic [lsu_pkg::XLEN-1:0]        pwdata_o,
    output logic [lsu_pkg::BE_W-1:0]        pstrb_o,
    input  logic                            pready_i,
    input  logic [lsu_pkg::XLEN-1:0]        prdata_i
);
    import lsu_pkg::*;

    logic [XLEN-1:0]       agu_vaddr;
    logic [BE_W-1:0]       agu_be;

    logic                  buf_valid;
    lsu_op_e               buf_op;
    logic [XLEN-1:0]       buf_vaddr;
    logic [BE_W-1:0]       buf_be;
    logic [XLEN-1:0]       buf_wdata;
    logic [TRANS_ID_W-1:0] buf_tid;
    logic                  take;

    logic                  chk_valid;
    lsu_op_e               chk_op;
    logic [XLEN-1:0]       chk_vaddr;
    logic [BE_W-1:0]       chk_be;
    logic [XLEN-1:0]       chk_wdata;
    logic [TRANS_ID_W-1:0] chk_tid;
    logic                  chk_ex;
    exc_cause_e            chk_cause;
    logic                  apb_ready;

    lsu_agu i_agu (
        .operator_i  (operator_i),
        .operand_a_i (operand_a_i),
        .imm_i       (imm_i),
        .vaddr_o     (agu_vaddr),
        .be_o        (agu_be)
    );

    lsu_req_buffer i_req_buffer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_valid_i    (lsu_valid_i),
        .operator_i     (operator_i),
        .vaddr_i        (agu_vaddr),
        .be_i           (agu_be),
        .wdata_i        (operand_b_i),
        .trans_id_i     (trans_id_i),
        .pop_i          (take),
        .ready_o        (lsu_ready_o),
        .out_valid_o    (buf_valid),
        .out_operator_o (buf_op),
        .out_vaddr_o    (buf_vaddr),
        .out_be_o       (buf_be),
        .out_wdata_o    (buf_wdata),
        .out_trans_id_o (buf_tid)
    );

    lsu_addr_check i_addr_check (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .in_valid_i     (buf_valid),
        .in_operator_i  (buf_op),
        .in_vaddr_i     (buf_vaddr),
        .in_be_i        (buf_be),
        .in_wdata_i     (buf_wdata),
        .in_trans_id_i  (buf_tid),
        .apb_ready_i    (apb_ready),
        .take_o         (take),
        .chk_valid_o    (chk_valid),
        .chk_operator_o (chk_op),
        .chk_vaddr_o    (chk_vaddr),
        .chk_be_o       (chk_be),
        .chk_wdata_o    (chk_wdata),
        .chk_trans_id_o (chk_tid),
        .chk_ex_o       (chk_ex),
        .chk_cause_o    (chk_cause)
    );

    lsu_apb_master i_apb_master (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .in_valid_i     (chk_valid),
        .in_operator_i  (chk_op),
        .in_vaddr_i     (chk_vaddr),
        .in_be_i        (chk_be),
        .in_wdata_i     (chk_wdata),
        .in_trans_id_i  (chk_tid),
        .in_ex_i        (chk_ex),
        .in_cause_i     (chk_cause),
        .ready_o        (apb_ready),
        .psel_o         (psel_o),
        .penable_o      (penable_o),
        .pwrite_o       (pwrite_o),
        .paddr_o        (paddr_o),
        .pwdata_o       (pwdata_o),
        .pstrb_o        (pstrb_o),
        .pready_i       (pready_i),
        .prdata_i       (prdata_i),
        .lsu_valid_o    (lsu_valid_o),
        .lsu_trans_id_o (lsu_trans_id_o),
        .lsu_result_o   (lsu_result_o),
        .ex_valid_o     (ex_valid_o),
        .ex_cause_o     (ex_cause_o),
        .ex_tval_o      (ex_tval_o)
    );

endmodule

`default_nettype wire

//--- rtl/lsu_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_apb_master (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            in_valid_i,
    input  lsu_pkg::lsu_op_e                in_operator_i,
    input  logic [lsu_pkg::XLEN-1:0]        in_vaddr_i,
    input  logic [lsu_pkg::BE_W-1:0]        in_be_i,
    input  logic [lsu_pkg::XLEN-1:0]        in_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]  in_trans_id_i,
    input  logic                            in_ex_i,
    input  lsu_pkg::exc_cause_e             in_cause_i,
    output logic                            ready_o,
    // APB master
    output logic                            psel_o,
    output logic                            penable_o,
    output logic                            pwrite_o,
    output logic [lsu_pkg::APB_ADDR_W-1:0]  paddr_o,
    output logic [lsu_pkg::XLEN-1:0]        pwdata_o,
    output logic [lsu_pkg::BE_W-1:0]        pstrb_o,
    input  logic                            pready_i,
    input  logic [lsu_pkg::XLEN-1:0]        prdata_i,
    // writeback
    output logic                            lsu_valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]  lsu_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]        lsu_result_o,
    output logic                            ex_valid_o,
    output lsu_pkg::exc_cause_e             ex_cause_o,
    output logic [lsu_pkg::XLEN-1:0]        ex_tval_o
);
    import lsu_pkg::*;

    apb_state_e            state_q;
    lsu_op_e               op_q;
    logic [XLEN-1:0]       vaddr_q;
    logic [BE_W-1:0]       be_q;
    logic [XLEN-1:0]       wdata_q;
    logic [TRANS_ID_W-1:0] tid_q;
    logic [XLEN-1:0]       rdata_shifted;
    logic [XLEN-1:0]       load_data;
    logic                  take;

    assign ready_o = (state_q == APB_IDLE);
    assign take    = ready_o && in_valid_i;

    // ------------------------------
    // bus outputs
    // ------------------------------
    assign psel_o    = (state_q != APB_IDLE);
    assign penable_o = (state_q == APB_ACCESS);
    assign pwrite_o  = op_is_store(op_q);
    assign paddr_o   = vaddr_q[APB_ADDR_W-1:0];
    // register data sits in the low lanes, move it to the addressed ones
    assign pwdata_o  = wdata_q << {vaddr_q[2:0], 3'b000};
    assign pstrb_o   = pwrite_o ? be_q : '0;

    // right-justify the addressed lanes, then extend
    assign rdata_shifted = prdata_i >> {vaddr_q[2:0], 3'b000};

    always_comb begin
        case (op_q)
            LB:      load_data = {{(XLEN-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
            LBU:     load_data = {{(XLEN-8){1'b0}}, rdata_shifted[7:0]};
            LH:      load_data = {{(XLEN-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
            LHU:     load_data = {{(XLEN-16){1'b0}}, rdata_shifted[15:0]};
            LW:      load_data = {{(XLEN-32){rdata_shifted[31]}}, rdata_shifted[31:0]};
            LWU:     load_data = {{(XLEN-32){1'b0}}, rdata_shifted[31:0]};
            LD:      load_data = rdata_shifted;
            default: load_data = '0;
        endcase
    end

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= APB_IDLE;
            lsu_valid_o <= 1'b0;
            ex_valid_o  <= 1'b0;
        end else begin
            lsu_valid_o <= 1'b0;
            ex_valid_o  <= 1'b0;
            case (state_q)
                APB_IDLE: begin
                    if (take && in_ex_i) begin
                        // no bus transfer, report straight away
                        lsu_valid_o <= 1'b1;
                        ex_valid_o  <= 1'b1;
                    end else if (take) begin
                        state_q <= APB_SETUP;
                    end
                end
                APB_SETUP: state_q <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready_i) begin
                        state_q     <= APB_IDLE;
                        lsu_valid_o <= 1'b1;
                    end
                end
                default: state_q <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            op_q    <= in_operator_i;
            vaddr_q <= in_vaddr_i;
            be_q    <= in_be_i;
            wdata_q <= in_wdata_i;
            tid_q   <= in_trans_id_i;
        end
        if (take && in_ex_i) begin
            lsu_trans_id_o <= in_trans_id_i;
            lsu_result_o   <= '0;
            ex_cause_o     <= in_cause_i;
            ex_tval_o      <= in_vaddr_i;
        end else if (state_q == APB_ACCESS && pready_i) begin
            lsu_trans_id_o <= tid_q;
            lsu_result_o   <= load_data;
            ex_cause_o     <= EXC_NONE;
            ex_tval_o      <= '0;
        end
    end

    // wait states must not disturb the transfer
    a_apb_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == APB_ACCESS && !pready_i) |=>
            (state_q == APB_ACCESS && $stable(paddr_o) && $stable(pwrite_o) &&
             $stable(pwdata_o) && $stable(pstrb_o)));

endmodule

`default_nettype wire

//--- rtl/lsu_addr_check.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_check (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            in_valid_i,
    input  lsu_pkg::lsu_op_e                in_operator_i,
    input  logic [lsu_pkg::XLEN-1:0]        in_vaddr_i,
    input  logic [lsu_pkg::BE_W-1:0]        in_be_i,
    input  logic [lsu_pkg::XLEN-1:0]        in_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]  in_trans_id_i,
    input  logic                            apb_ready_i,
    output logic                            take_o,
    output logic                            chk_valid_o,
    output lsu_pkg::lsu_op_e                chk_operator_o,
    output logic [lsu_pkg::XLEN-1:0]        chk_vaddr_o,
    output logic [lsu_pkg::BE_W-1:0]        chk_be_o,
    output logic [lsu_pkg::XLEN-1:0]        chk_wdata_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]  chk_trans_id_o,
    output logic                            chk_ex_o,
    output lsu_pkg::exc_cause_e             chk_cause_o
);
    import lsu_pkg::*;

    logic       misaligned;
    logic       canonical;
    logic       is_store;
    exc_cause_e cause;

    // free, or the APB stage drains it this cycle
    assign take_o   = !chk_valid_o || apb_ready_i;
    assign is_store = op_is_store(in_operator_i);

    always_comb begin
        case (op_size(in_operator_i))
            2'd3:    misaligned = |in_vaddr_i[2:0];
            2'd2:    misaligned = |in_vaddr_i[1:0];
            2'd1:    misaligned = in_vaddr_i[0];
            default: misaligned = 1'b0;
        endcase
    end

    assign canonical = (&in_vaddr_i[XLEN-1:VA_BITS]) || !(|in_vaddr_i[XLEN-1:VA_BITS]);

    // page fault wins over misalignment
    always_comb begin
        cause = EXC_NONE;
        if (misaligned) begin
            cause = is_store ? EXC_ST_MISALIGNED : EXC_LD_MISALIGNED;
        end
        if (!canonical) begin
            cause = is_store ? EXC_ST_PAGE_FAULT : EXC_LD_PAGE_FAULT;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            chk_valid_o <= 1'b0;
        end else if (take_o) begin
            chk_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o && in_valid_i) begin
            chk_operator_o <= in_operator_i;
            chk_vaddr_o    <= in_vaddr_i;
            chk_be_o       <= in_be_i;
            chk_wdata_o    <= in_wdata_i;
            chk_trans_id_o <= in_trans_id_i;
            chk_ex_o       <= misaligned || !canonical;
            chk_cause_o    <= cause;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_req_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_buffer (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            req_valid_i,
    input  lsu_pkg::lsu_op_e                operator_i,
    input  logic [lsu_pkg::XLEN-1:0]        vaddr_i,
    input  logic [lsu_pkg::BE_W-1:0]        be_i,
    input  logic [lsu_pkg::XLEN-1:0]        wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]  trans_id_i,
    input  logic                            pop_i,
    output logic                            ready_o,
    output logic                            out_valid_o,
    output lsu_pkg::lsu_op_e                out_operator_o,
    output logic [lsu_pkg::XLEN-1:0]        out_vaddr_o,
    output logic [lsu_pkg::BE_W-1:0]        out_be_o,
    output logic [lsu_pkg::XLEN-1:0]        out_wdata_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]  out_trans_id_o
);
    import lsu_pkg::*;

    lsu_op_e               op_mem   [2];
    logic [XLEN-1:0]       vaddr_mem[2];
    logic [BE_W-1:0]       be_mem   [2];
    logic [XLEN-1:0]       wdata_mem[2];
    logic [TRANS_ID_W-1:0] tid_mem  [2];

    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] count_q;
    logic       empty;
    logic       push;
    logic       pop_mem;

    assign empty   = (count_q == 2'd0);
    assign ready_o = empty;

    // an accepted request is stored unless it bypasses straight through
    assign push    = req_valid_i && ready_o && !(empty && pop_i);
    assign pop_mem = pop_i && !empty;

    // ------------------------------
    // output select
    // ------------------------------
    assign out_valid_o    = empty ? req_valid_i : 1'b1;
    assign out_operator_o = empty ? operator_i  : op_mem[rd_ptr_q];
    assign out_vaddr_o    = empty ? vaddr_i     : vaddr_mem[rd_ptr_q];
    assign out_be_o       = empty ? be_i        : be_mem[rd_ptr_q];
    assign out_wdata_o    = empty ? wdata_i     : wdata_mem[rd_ptr_q];
    assign out_trans_id_o = empty ? trans_id_i  : tid_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            op_mem[wr_ptr_q]    <= operator_i;
            vaddr_mem[wr_ptr_q] <= vaddr_i;
            be_mem[wr_ptr_q]    <= be_i;
            wdata_mem[wr_ptr_q] <= wdata_i;
            tid_mem[wr_ptr_q]   <= trans_id_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop_mem) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop_mem};
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (count_q == 2'd2) |-> !push);

endmodule

`default_nettype wire

//--- rtl/lsu_agu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  lsu_pkg::lsu_op_e              operator_i,
    input  logic [lsu_pkg::XLEN-1:0]      operand_a_i,
    input  logic [lsu_pkg::XLEN-1:0]      imm_i,
    output logic [lsu_pkg::XLEN-1:0]      vaddr_o,
    output logic [lsu_pkg::BE_W-1:0]      be_o
);
    import lsu_pkg::*;

    logic [BE_W-1:0]   size_mask;
    logic [2*BE_W-1:0] be_wide;

    // two's complement add covers the signed immediate
    assign vaddr_o = operand_a_i + imm_i;

    always_comb begin
        case (op_size(operator_i))
            2'd0:    size_mask = 8'b0000_0001;
            2'd1:    size_mask = 8'b0000_0011;
            2'd2:    size_mask = 8'b0000_1111;
            default: size_mask = 8'b1111_1111;
        endcase
    end

    // lanes pushed past the doubleword edge kill the whole enable
    assign be_wide = {{BE_W{1'b0}}, size_mask} << vaddr_o[2:0];
    assign be_o    = (|be_wide[2*BE_W-1:BE_W]) ? '0 : be_wide[BE_W-1:0];

endmodule

`default_nettype wire

//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int XLEN       = 64;
    localparam int BE_W       = 8;
    localparam int TRANS_ID_W = 3;
    localparam int APB_ADDR_W = 16;
    // bits from here up must be all ones or all zeros
    localparam int VA_BITS    = 39;

    // ------------------------------
    // encodings
    // ------------------------------
    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } lsu_op_e;

    // RISC-V mcause codes for data accesses
    typedef enum logic [3:0] {
        EXC_NONE          = 4'd0,
        EXC_LD_MISALIGNED = 4'd4,
        EXC_ST_MISALIGNED = 4'd6,
        EXC_LD_PAGE_FAULT = 4'd13,
        EXC_ST_PAGE_FAULT = 4'd15
    } exc_cause_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    function automatic logic op_is_store(lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            LW, LWU, SW: return 2'd2;
            default:     return 2'd3;
        endcase
    endfunction

endpackage

`default_nettype wire
